/* hw/gat_cfg_pkg.sv */
package gat_cfg_pkg;

  // Node feature vector after projection
  localparam int NUM_FEAT    = 4;
  localparam int WH_W        = 12;

  // Attention vector, target half followed by neighbor half
  localparam int ATT_LEN     = 2 * NUM_FEAT;
  localparam int ATT_W       = 8;

  // Two half dot products added together
  localparam int SCORE_W     = 23;

  // Coefficient after leaky ReLU and saturation
  localparam int COEF_W      = 8;
  localparam int LRELU_SHIFT = 3;

  // Aggregated output feature
  localparam int AGGR_W      = 32;

  // Largest subgraph, self loop included
  localparam int MAX_NODES   = 16;

  // Coefficient and feature buffers
  localparam int FIFO_DEPTH  = 16;
  localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
  localparam int FIFO_CW     = $clog2(FIFO_DEPTH + 1);

endpackage

/* hw/gat_types_pkg.sv */
package gat_types_pkg;

  import gat_cfg_pkg::*;

  // One node's projected features, element i holds feature i
  typedef logic [NUM_FEAT-1:0][WH_W-1:0] wh_vec_t;

  // Elements 0 .. NUM_FEAT-1 weight the target node,
  // elements NUM_FEAT .. ATT_LEN-1 weight the neighbor
  typedef logic [ATT_LEN-1:0][ATT_W-1:0] att_vec_t;

  // Unnormalized attention coefficient
  typedef logic signed [COEF_W-1:0] coef_t;

  // Coefficient buffer entry
  typedef struct packed {
    logic  last;
    coef_t coef;
  } coef_entry_t;

  // New feature vector of the target node, element i holds feature i
  typedef logic [NUM_FEAT-1:0][AGGR_W-1:0] feat_vec_t;

endpackage

/* hw/sync_fifo.sv */
module sync_fifo
  import gat_cfg_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     wr_i,
  input  payload_t din_i,

  input  logic     rd_i,
  output payload_t dout_o,

  output logic     empty_o,
  output logic     full_o
);

  payload_t           mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_CW-1:0] count;

  // Head is visible without a read request
  assign dout_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign full_o  = (count == FIFO_CW'(FIFO_DEPTH));

  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr <= (wr_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_i) begin
        rd_ptr <= (rd_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({wr_i, rd_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer rate never exceeds the drain rate
  no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_i |-> !full_o
  ) else $error("write into a full FIFO");

  // Consumer only pops what is there
  no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_i |-> !empty_o
  ) else $error("pop from an empty FIFO");

endmodule

/* hw/attention_scorer.sv */
module attention_scorer
  import gat_cfg_pkg::*;
  import gat_types_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  logic        a_vld_i,
  input  att_vec_t    a_i,

  input  logic        wh_vld_i,
  input  wh_vec_t     wh_i,
  input  logic        first_i,
  input  logic        last_i,

  output logic        wr_o,
  output coef_entry_t entry_o,
  output wh_vec_t     wh_o
);

  att_vec_t                  a_q;

  logic signed [SCORE_W-2:0] dot_tgt;
  logic signed [SCORE_W-2:0] dot_nbr;

  logic                      s1_vld;
  logic                      s1_last;
  logic signed [SCORE_W-2:0] tgt_q;
  logic signed [SCORE_W-2:0] nbr_q;
  wh_vec_t                   wh_q;

  logic signed [SCORE_W-1:0] score;
  logic signed [SCORE_W-1:0] lrelu;
  logic                      in_range;
  coef_t                     coef_sat;

  // Attention vector, a new one applies from the next cycle on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q <= '0;
    end else if (a_vld_i) begin
      a_q <= a_i;
    end
  end

  // Both half dot products of the incoming node
  always_comb begin
    dot_tgt = '0;
    dot_nbr = '0;
    for (int i = 0; i < NUM_FEAT; i++) begin
      dot_tgt = dot_tgt + $signed(a_q[i]) * $signed(wh_i[i]);
      dot_nbr = dot_nbr + $signed(a_q[NUM_FEAT+i]) * $signed(wh_i[i]);
    end
  end

  // Stage 1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= wh_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      nbr_q   <= dot_nbr;
      wh_q    <= wh_i;
      s1_last <= last_i;
    end
    // Target term is kept for the rest of the subgraph
    if (wh_vld_i && first_i) begin
      tgt_q <= dot_tgt;
    end
  end

  // Stage 2, score and leaky ReLU
  always_comb begin
    score = SCORE_W'(tgt_q) + SCORE_W'(nbr_q);
    if (score[SCORE_W-1]) begin
      lrelu = score >>> LRELU_SHIFT;
    end else begin
      lrelu = score;
    end
  end

  // Saturate to COEF_W, fits when all upper bits match the sign
  always_comb begin
    in_range = (&lrelu[SCORE_W-1:COEF_W-1]) || !(|lrelu[SCORE_W-1:COEF_W-1]);
    if (in_range) begin
      coef_sat = lrelu[COEF_W-1:0];
    end else if (lrelu[SCORE_W-1]) begin
      coef_sat = {1'b1, {(COEF_W-1){1'b0}}};
    end else begin
      coef_sat = {1'b0, {(COEF_W-1){1'b1}}};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_o <= 1'b0;
    end else begin
      wr_o <= s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld) begin
      entry_o.coef <= coef_sat;
      entry_o.last <= s1_last;
      wh_o         <= wh_q;
    end
  end

  // The target term and the vector must come from one consistent load
  a_stable_on_first: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wh_vld_i && first_i) |-> !a_vld_i
  ) else $error("attention vector loaded together with a target node");

endmodule

/* hw/neighbor_aggregator.sv */
module neighbor_aggregator
  import gat_cfg_pkg::*;
  import gat_types_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  coef_entry_t entry_i,
  input  wh_vec_t     wh_i,
  input  logic        empty_i,
  output logic        rd_o,

  output logic        feat_vld_o,
  output feat_vec_t   feat_o
);

  logic                     pop;
  logic                     pop_last;
  logic signed [AGGR_W-1:0] acc [NUM_FEAT];
  logic signed [AGGR_W-1:0] sum [NUM_FEAT];

  // Drains one entry per cycle
  assign pop      = !empty_i;
  assign rd_o     = pop;
  assign pop_last = pop && entry_i.last;

  // Running sum including the head entry
  always_comb begin
    for (int i = 0; i < NUM_FEAT; i++) begin
      sum[i] = acc[i] + $signed(entry_i.coef) * $signed(wh_i[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_vld_o <= 1'b0;
      for (int i = 0; i < NUM_FEAT; i++) begin
        acc[i] <= '0;
      end
    end else begin
      feat_vld_o <= pop_last;
      if (pop) begin
        for (int i = 0; i < NUM_FEAT; i++) begin
          // Restart for the next subgraph
          acc[i] <= pop_last ? '0 : sum[i];
        end
      end
    end
  end

  // Final sums of the subgraph
  always_ff @(posedge clk) begin
    if (pop_last) begin
      for (int i = 0; i < NUM_FEAT; i++) begin
        feat_o[i] <= sum[i];
      end
    end
  end

endmodule

/* hw/gat_layer_top.sv */
module gat_layer_top
  import gat_types_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  logic      a_vld_i,
  input  att_vec_t  a_i,

  input  logic      wh_vld_i,
  input  wh_vec_t   wh_i,
  input  logic      first_i,
  input  logic      last_i,

  output logic      feat_vld_o,
  output feat_vec_t feat_o
);

  logic        coef_wr;
  coef_entry_t coef_entry;
  wh_vec_t     nbr_wh;

  logic        ff_rd;
  logic        coef_empty;
  coef_entry_t coef_head;
  wh_vec_t     wh_head;

  attention_scorer u_scorer (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .a_vld_i    (a_vld_i    ),
    .a_i        (a_i        ),
    .wh_vld_i   (wh_vld_i   ),
    .wh_i       (wh_i       ),
    .first_i    (first_i    ),
    .last_i     (last_i     ),
    .wr_o       (coef_wr    ),
    .entry_o    (coef_entry ),
    .wh_o       (nbr_wh     )
  );

  // Both buffers are written and popped together
  sync_fifo #(
    .payload_t  (coef_entry_t)
  ) u_coef_fifo (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .wr_i       (coef_wr    ),
    .din_i      (coef_entry ),
    .rd_i       (ff_rd      ),
    .dout_o     (coef_head  ),
    .empty_o    (coef_empty ),
    .full_o     (           )
  );

  sync_fifo #(
    .payload_t  (wh_vec_t   )
  ) u_wh_fifo (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .wr_i       (coef_wr    ),
    .din_i      (nbr_wh     ),
    .rd_i       (ff_rd      ),
    .dout_o     (wh_head    ),
    .empty_o    (           ),
    .full_o     (           )
  );

  neighbor_aggregator u_aggregator (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .entry_i    (coef_head  ),
    .wh_i       (wh_head    ),
    .empty_i    (coef_empty ),
    .rd_o       (ff_rd      ),
    .feat_vld_o (feat_vld_o ),
    .feat_o     (feat_o     )
  );

endmodule

/* bench/gat_ref_model.svh */
`ifndef GAT_REF_MODEL_SVH
`define GAT_REF_MODEL_SVH

// Model state, follows the node strobes
att_vec_t  model_att;
wh_vec_t   model_tgt;
int        model_acc [NUM_FEAT];
feat_vec_t exp_q [$];

// Base 0 selects the target half, base NUM_FEAT the neighbor half
function automatic int half_dot(att_vec_t a, int base, wh_vec_t wh);
  int sum;
  int av;
  int wv;
  sum = 0;
  for (int i = 0; i < NUM_FEAT; i++) begin
    av = $signed(a[base+i]);
    wv = $signed(wh[i]);
    sum += av * wv;
  end
  return sum;
endfunction

function automatic coef_t leaky_sat(int score);
  int v;
  int div;
  int hi;
  int lo;
  div = 1 << LRELU_SHIFT;
  hi  = (1 << (COEF_W - 1)) - 1;
  lo  = -(1 << (COEF_W - 1));
  v   = score;
  if (v < 0) begin
    // Floor of the quotient
    v = -((-v + div - 1) / div);
  end
  if (v > hi) begin
    v = hi;
  end else if (v < lo) begin
    v = lo;
  end
  return coef_t'(v);
endfunction

task automatic model_node(wh_vec_t wh, logic first, logic last);
  coef_t     c;
  int        cv;
  int        wv;
  feat_vec_t f;
  if (first) begin
    model_tgt = wh;
    for (int i = 0; i < NUM_FEAT; i++) begin
      model_acc[i] = 0;
    end
  end
  c  = leaky_sat(half_dot(model_att, 0, model_tgt) + half_dot(model_att, NUM_FEAT, wh));
  cv = c;
  for (int i = 0; i < NUM_FEAT; i++) begin
    wv = $signed(wh[i]);
    model_acc[i] += cv * wv;
    f[i] = AGGR_W'(model_acc[i]);
  end
  if (last) begin
    exp_q.push_back(f);
  end
endtask

task automatic compare_feat(feat_vec_t exp, feat_vec_t act);
  if (act !== exp) begin
    $display("ERROR at %0t: feat_o expected %h actual %h", $time, exp, act);
    errors++;
  end
endtask

task automatic compare_count(int exp, int act);
  if (act != exp) begin
    $display("ERROR at %0t: feat_vld_o pulses expected %0d actual %0d", $time, exp, act);
    errors++;
  end
endtask

`endif

/* bench/tb_gat_layer.sv */
module tb_gat_layer
  import gat_cfg_pkg::*;
  import gat_types_pkg::*;
();

  logic      clk;
  logic      rst_n;
  logic      a_vld_i;
  att_vec_t  a_i;
  logic      wh_vld_i;
  wh_vec_t   wh_i;
  logic      first_i;
  logic      last_i;
  logic      feat_vld_o;
  feat_vec_t feat_o;

  int seed;
  int errors         = 0;
  int tests_passed   = 0;
  int tests_failed   = 0;
  int nodes_sent     = 0;
  int subgraphs_sent = 0;
  int outputs_seen   = 0;
  int cycles         = 0;
  int test_errors;
  int test_subgraphs;
  int test_outputs;

  `include "gat_ref_model.svh"

  gat_layer_top i_gat_layer_top (
    .clk        (clk       ),
    .rst_n      (rst_n     ),
    .a_vld_i    (a_vld_i   ),
    .a_i        (a_i       ),
    .wh_vld_i   (wh_vld_i  ),
    .wh_i       (wh_i      ),
    .first_i    (first_i   ),
    .last_i     (last_i    ),
    .feat_vld_o (feat_vld_o),
    .feat_o     (feat_o    )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Limit grows with every node sent
  initial begin
    while (cycles < 20 * nodes_sent + 50) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run timed out after %0d cycles with %0d nodes sent", cycles, nodes_sent);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // Outputs are registered, stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && feat_vld_o) begin
      outputs_seen++;
      if (exp_q.size() == 0) begin
        $display("Unexpected output at %0t, feat_vld_o pulsed with no subgraph pending", $time);
        errors++;
      end else begin
        compare_feat(exp_q.pop_front(), feat_o);
      end
    end
  end

  function automatic int rand_range(int lo, int hi);
    int r;
    r = $random(seed);
    return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
  endfunction

  function automatic wh_vec_t rand_wh(logic extreme);
    wh_vec_t wh;
    for (int i = 0; i < NUM_FEAT; i++) begin
      if (extreme) begin
        wh[i] = rand_range(0, 1) ? {1'b0, {(WH_W-1){1'b1}}} : {1'b1, {(WH_W-1){1'b0}}};
      end else begin
        wh[i] = WH_W'($random(seed));
      end
    end
    return wh;
  endfunction

  // Mode 0 all largest, 1 all smallest, 2 mixed extremes, else random
  function automatic att_vec_t make_att(int mode);
    att_vec_t a;
    for (int i = 0; i < ATT_LEN; i++) begin
      case (mode)
        0: a[i] = {1'b0, {(ATT_W-1){1'b1}}};
        1: a[i] = {1'b1, {(ATT_W-1){1'b0}}};
        2: a[i] = rand_range(0, 1) ? {1'b0, {(ATT_W-1){1'b1}}} : {1'b1, {(ATT_W-1){1'b0}}};
        default: a[i] = ATT_W'($random(seed));
      endcase
    end
    return a;
  endfunction

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(negedge clk);
      a_vld_i  = 1'b0;
      wh_vld_i = 1'b0;
      first_i  = 1'b0;
      last_i   = 1'b0;
    end
  endtask

  task automatic load_att(att_vec_t a);
    @(negedge clk);
    wh_vld_i  = 1'b0;
    first_i   = 1'b0;
    last_i    = 1'b0;
    a_vld_i   = 1'b1;
    a_i       = a;
    model_att = a;
  endtask

  task automatic send_node(wh_vec_t wh, logic first, logic last);
    @(negedge clk);
    a_vld_i  = 1'b0;
    wh_vld_i = 1'b1;
    wh_i     = wh;
    first_i  = first;
    last_i   = last;
    model_node(wh, first, last);
    nodes_sent++;
    if (last) begin
      subgraphs_sent++;
    end
  endtask

  task automatic send_subgraph(int n, int max_gap, logic extreme);
    for (int k = 0; k < n; k++) begin
      send_node(rand_wh(extreme), k == 0, k == n - 1);
      if (max_gap > 0) begin
        idle_cycles(rand_range(0, max_gap));
      end
    end
  endtask

  task automatic start_test();
    test_errors    = errors;
    test_subgraphs = subgraphs_sent;
    test_outputs   = outputs_seen;
  endtask

  task automatic end_test(string name);
    idle_cycles(1);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    // A few more cycles to catch extra pulses
    idle_cycles(3);
    compare_count(subgraphs_sent - test_subgraphs, outputs_seen - test_outputs);
    if (errors == test_errors) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - test_errors);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    a_vld_i   = 1'b0;
    a_i       = '0;
    wh_vld_i  = 1'b0;
    wh_i      = '0;
    first_i   = 1'b0;
    last_i    = 1'b0;
    seed      = 32'hf45d_93bf;
    model_att = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    start_test();
    idle_cycles(10);
    end_test("idle after reset");

    start_test();
    load_att(make_att(3));
    repeat (8) send_subgraph(1, 0, 1'b0);
    end_test("single node subgraphs");

    start_test();
    repeat (20) send_subgraph(rand_range(1, MAX_NODES), 0, 1'b0);
    end_test("random back to back");

    start_test();
    for (int m = 0; m < 3; m++) begin
      load_att(make_att(m));
      repeat (4) send_subgraph(rand_range(1, MAX_NODES), 0, 1'b1);
      send_subgraph(rand_range(1, MAX_NODES), 0, 1'b0);
    end
    end_test("extreme values");

    // New vector right behind the last node of a subgraph
    start_test();
    repeat (6) begin
      load_att(make_att(3));
      send_subgraph(rand_range(1, MAX_NODES), 0, 1'b0);
    end
    end_test("attention reload");

    start_test();
    repeat (10) send_subgraph(rand_range(1, MAX_NODES), 3, 1'b0);
    end_test("idle gaps");

    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+bench
hw/gat_cfg_pkg.sv
hw/gat_types_pkg.sv
hw/sync_fifo.sv
hw/attention_scorer.sv
hw/neighbor_aggregator.sv
hw/gat_layer_top.sv
bench/tb_gat_layer.sv

/* Bender.yml */
package:
  name: gat_layer

sources:
  - files:
      - hw/gat_cfg_pkg.sv
      - hw/gat_types_pkg.sv
      - hw/sync_fifo.sv
      - hw/attention_scorer.sv
      - hw/neighbor_aggregator.sv
      - hw/gat_layer_top.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_gat_layer.sv
